// ==== source/lpif_link_pkg.sv ====
/* Shared widths, link word layout and sync states for the one-channel logic link.
   Modules import this package inside their bodies and use scoped names in their headers. */
`default_nettype none

package lpif_link_pkg;

  //////////////////////////////////////////////////
  // Word and lane sizes
  //////////////////////////////////////////////////

  // Packed downstream/upstream word
  localparam int LINK_WORD_W = 89;
  // One die-to-die PHY lane
  localparam int PHY_LANE_W  = 40;
  // Three lanes side by side
  localparam int LANE_VEC_W  = 3 * PHY_LANE_W;

  //////////////////////////////////////////////////
  // Field offsets inside the link word
  //////////////////////////////////////////////////

  localparam int OFS_DATA      = 0;   // 64 bits
  localparam int OFS_CRC       = 64;  // 16 bits
  localparam int OFS_STATE     = 80;  // 4 bits
  localparam int OFS_PROTID    = 84;  // 2 bits
  localparam int OFS_DVALID    = 86;
  localparam int OFS_CRC_VALID = 87;
  localparam int OFS_VALID     = 88;

  // Sideband bits in the lane vector, above the word
  localparam int STB_BIT = 89;
  localparam int MRK_BIT = 90;

  //////////////////////////////////////////////////
  // Auto-sync
  //////////////////////////////////////////////////

  // Strobe period in cycles
  localparam int STROBE_INTERVAL = 8;
  localparam int STB_CNT_W       = $clog2(STROBE_INTERVAL);

  // Transmit online FSM
  typedef enum logic [1:0] {
    sync_offline,
    sync_counting,
    sync_online
  } sync_state_t;

endpackage

`default_nettype wire

// ==== source/link_auto_sync.sv ====
/* Delays the link online status by programmable counts and makes the periodic strobe.
   Feeds the lane concat block with tx/rx online levels and the strobe bit. */
`default_nettype none

module link_auto_sync (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  input  logic [7:0] delay_yz_value,
  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       tx_strobe
);

  import lpif_link_pkg::*;

  sync_state_t          tx_state;
  logic [7:0]           tx_cnt;
  logic [7:0]           rx_x_cnt;
  logic [7:0]           rx_yz_cnt;
  logic                 rx_x_done;
  logic                 rx_yz_done;
  logic [STB_CNT_W-1:0] stb_cnt;

  //////////////////////////////////////////////////
  // Transmit side
  //////////////////////////////////////////////////

  // Count starts at 1 on entry, so a delay of N lands N edges later
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= sync_offline;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        sync_offline: begin
          tx_cnt <= 8'd1;
          if (tx_online) begin
            // Zero delay goes straight online
            tx_state <= (delay_xz_value == 8'd0) ? sync_online : sync_counting;
          end
        end
        sync_counting: begin
          if (!tx_online) begin
            tx_state <= sync_offline;
          end else if (tx_cnt >= delay_xz_value) begin
            tx_state <= sync_online;
          end else begin
            // Saturating count
            tx_cnt <= tx_cnt + 8'd1;
          end
        end
        sync_online: begin
          if (!tx_online) begin
            tx_state <= sync_offline;
          end
        end
        default: begin
          tx_state <= sync_offline;
        end
      endcase
    end
  end

  assign tx_online_delay = (tx_state == sync_online);

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  // Each counter holds at its threshold
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_x_cnt  <= '0;
      rx_yz_cnt <= '0;
    end else begin
      if (!rx_online) begin
        rx_x_cnt <= '0;
      end else if (rx_x_cnt < delay_x_value) begin
        rx_x_cnt <= rx_x_cnt + 8'd1;
      end
      // Far side must have been online long enough too
      if (!tx_online_delay) begin
        rx_yz_cnt <= '0;
      end else if (rx_yz_cnt < delay_yz_value) begin
        rx_yz_cnt <= rx_yz_cnt + 8'd1;
      end
    end
  end

  assign rx_x_done  = rx_online && (rx_x_cnt >= delay_x_value);
  assign rx_yz_done = tx_online_delay && (rx_yz_cnt >= delay_yz_value);

  // Later of the two conditions wins; drops on the edge after rx_online falls
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_online_delay <= 1'b0;
    end else begin
      rx_online_delay <= rx_x_done && rx_yz_done;
    end
  end

  //////////////////////////////////////////////////
  // Periodic strobe
  //////////////////////////////////////////////////

  // Phase zero lines up with the first online cycle
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay) begin
      stb_cnt <= '0;
    end else if (stb_cnt == STB_CNT_W'(STROBE_INTERVAL - 1)) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + STB_CNT_W'(1);
    end
  end

  assign tx_strobe = tx_online_delay && (stb_cnt == '0);

endmodule

`default_nettype wire

// ==== source/lpif_field_pack.sv ====
/* Packs the downstream LPIF fields into a registered link word and unpacks
   the received word onto the upstream fields, gated by the word-ok qualifier. */
`default_nettype none

module lpif_field_pack (
  input  logic                                clk_wr,
  input  logic                                rst_n,
  // Downstream fields
  input  logic [3:0]                          dstrm_state,
  input  logic [1:0]                          dstrm_protid,
  input  logic [63:0]                         dstrm_data,
  input  logic                                dstrm_dvalid,
  input  logic [15:0]                         dstrm_crc,
  input  logic                                dstrm_crc_valid,
  input  logic                                dstrm_valid,
  // Received word
  input  logic [lpif_link_pkg::LINK_WORD_W-1:0] rx_word,
  input  logic                                rx_word_ok,
  // Word to the lanes
  output logic [lpif_link_pkg::LINK_WORD_W-1:0] tx_word,
  // Upstream fields
  output logic [3:0]                          ustrm_state,
  output logic [1:0]                          ustrm_protid,
  output logic [63:0]                         ustrm_data,
  output logic                                ustrm_dvalid,
  output logic [15:0]                         ustrm_crc,
  output logic                                ustrm_crc_valid,
  output logic                                ustrm_valid
);

  import lpif_link_pkg::*;

  //////////////////////////////////////////////////
  // Transmit pack
  //////////////////////////////////////////////////

  // One register stage; every bit of the word is covered
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_word <= '0;
    end else begin
      tx_word[OFS_DATA +: 64]     <= dstrm_data;
      tx_word[OFS_CRC +: 16]      <= dstrm_crc;
      tx_word[OFS_STATE +: 4]     <= dstrm_state;
      tx_word[OFS_PROTID +: 2]    <= dstrm_protid;
      tx_word[OFS_DVALID]         <= dstrm_dvalid;
      tx_word[OFS_CRC_VALID]      <= dstrm_crc_valid;
      tx_word[OFS_VALID]          <= dstrm_valid;
    end
  end

  //////////////////////////////////////////////////
  // Receive unpack
  //////////////////////////////////////////////////

  // Combinational slice; all zero until the word is qualified
  always_comb begin
    ustrm_data      = '0;
    ustrm_crc       = '0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    if (rx_word_ok) begin
      ustrm_data      = rx_word[OFS_DATA +: 64];
      ustrm_crc       = rx_word[OFS_CRC +: 16];
      ustrm_state     = rx_word[OFS_STATE +: 4];
      ustrm_protid    = rx_word[OFS_PROTID +: 2];
      ustrm_dvalid    = rx_word[OFS_DVALID];
      ustrm_crc_valid = rx_word[OFS_CRC_VALID];
      ustrm_valid     = rx_word[OFS_VALID];
    end
  end

endmodule

`default_nettype wire

// ==== source/phy_lane_concat.sv ====
/* Spreads the link word, strobe and marker over three 40-bit PHY lanes, and
   gathers the received lanes back into a word qualified by marker and online state. */
`default_nettype none

module phy_lane_concat (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic [lpif_link_pkg::LINK_WORD_W-1:0] tx_word,
  input  logic                                  tx_online_delay,
  input  logic                                  tx_strobe,
  input  logic                                  rx_online_delay,
  // Received lanes
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0]  rx_phy0,
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0]  rx_phy1,
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0]  rx_phy2,
  // Transmitted lanes
  output logic [lpif_link_pkg::PHY_LANE_W-1:0]  tx_phy0,
  output logic [lpif_link_pkg::PHY_LANE_W-1:0]  tx_phy1,
  output logic [lpif_link_pkg::PHY_LANE_W-1:0]  tx_phy2,
  // Received word
  output logic [lpif_link_pkg::LINK_WORD_W-1:0] rx_word,
  output logic                                  rx_word_ok
);

  import lpif_link_pkg::*;

  logic [LANE_VEC_W-1:0] tx_vec;
  logic [LANE_VEC_W-1:0] rx_vec;
  logic                  rx_mrk;

  //////////////////////////////////////////////////
  // Transmit
  //////////////////////////////////////////////////

  // Word in the low bits, then strobe and marker
  always_comb begin
    tx_vec                       = '0;
    tx_vec[LINK_WORD_W-1:0]      = tx_word;
    tx_vec[STB_BIT]              = tx_strobe;
    // Persistent marker, set on every word
    tx_vec[MRK_BIT]              = 1'b1;
  end

  // Lanes idle at zero while offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      tx_phy2 <= '0;
    end else if (tx_online_delay) begin
      tx_phy0 <= tx_vec[0*PHY_LANE_W +: PHY_LANE_W];
      tx_phy1 <= tx_vec[1*PHY_LANE_W +: PHY_LANE_W];
      tx_phy2 <= tx_vec[2*PHY_LANE_W +: PHY_LANE_W];
    end else begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      tx_phy2 <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Receive
  //////////////////////////////////////////////////

  // Same lane order as transmit
  assign rx_vec = {rx_phy2, rx_phy1, rx_phy0};

  // Only the word and marker are kept; strobe and spare bits are dropped
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_word <= '0;
      rx_mrk  <= 1'b0;
    end else begin
      rx_word <= rx_vec[LINK_WORD_W-1:0];
      rx_mrk  <= rx_vec[MRK_BIT];
    end
  end

  // Marker present and receive side online
  assign rx_word_ok = rx_online_delay && rx_mrk;

endmodule

`default_nettype wire

// ==== source/lpif_link_top.sv ====
/* Top of the one-channel logic link between the LPIF adapter and three PHY lanes.
   Wires auto-sync, field pack and lane concat together in the clk_wr domain. */
`default_nettype none

module lpif_link_top (
  input  logic                                 clk_wr,
  input  logic                                 rst_n,
  // Link control
  input  logic                                 tx_online,
  input  logic                                 rx_online,
  input  logic [7:0]                           delay_x_value,
  input  logic [7:0]                           delay_xz_value,
  input  logic [7:0]                           delay_yz_value,
  // Downstream channel
  input  logic [3:0]                           dstrm_state,
  input  logic [1:0]                           dstrm_protid,
  input  logic [63:0]                          dstrm_data,
  input  logic                                 dstrm_dvalid,
  input  logic [15:0]                          dstrm_crc,
  input  logic                                 dstrm_crc_valid,
  input  logic                                 dstrm_valid,
  // PHY lanes
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0] rx_phy0,
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0] rx_phy1,
  input  logic [lpif_link_pkg::PHY_LANE_W-1:0] rx_phy2,
  output logic [lpif_link_pkg::PHY_LANE_W-1:0] tx_phy0,
  output logic [lpif_link_pkg::PHY_LANE_W-1:0] tx_phy1,
  output logic [lpif_link_pkg::PHY_LANE_W-1:0] tx_phy2,
  // Upstream channel
  output logic [3:0]                           ustrm_state,
  output logic [1:0]                           ustrm_protid,
  output logic [63:0]                          ustrm_data,
  output logic                                 ustrm_dvalid,
  output logic [15:0]                          ustrm_crc,
  output logic                                 ustrm_crc_valid,
  output logic                                 ustrm_valid
);

  import lpif_link_pkg::*;

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  logic                   tx_online_delay;
  logic                   rx_online_delay;
  logic                   tx_strobe;
  logic [LINK_WORD_W-1:0] tx_word;
  logic [LINK_WORD_W-1:0] rx_word;
  logic                   rx_word_ok;

  // Online delays and strobe
  link_auto_sync i_link_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_strobe       (tx_strobe)
  );

  // Field pack/unpack
  lpif_field_pack i_lpif_field_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .tx_word         (tx_word),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // Lane mapping
  phy_lane_concat i_phy_lane_concat (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_word         (tx_word),
    .tx_online_delay (tx_online_delay),
    .tx_strobe       (tx_strobe),
    .rx_online_delay (rx_online_delay),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok)
  );

endmodule

`default_nettype wire

// ==== bench/lpif_link_tb.sv ====
/* Testbench for the logic link. Loops the tx lanes back to rx and runs each phase
   of the stimulus file, checking lane timing, strobe, receive gating and data. */
`default_nettype none

module lpif_link_tb;

  import lpif_link_pkg::*;

  localparam int          TIMEOUT_CYCLES = 300;
  localparam logic [31:0] LFSR_SEED      = 32'h71ef9f86;
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

  // One downstream beat as the testbench sees it
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [15:0] crc;
    logic        crc_valid;
    logic        valid;
  } word_fields_t;

  logic                  clk_wr;
  logic                  rst_n;
  logic                  tx_online;
  logic                  rx_online;
  logic [7:0]            delay_x_value;
  logic [7:0]            delay_xz_value;
  logic [7:0]            delay_yz_value;
  logic [3:0]            dstrm_state;
  logic [1:0]            dstrm_protid;
  logic [63:0]           dstrm_data;
  logic                  dstrm_dvalid;
  logic [15:0]           dstrm_crc;
  logic                  dstrm_crc_valid;
  logic                  dstrm_valid;
  logic [PHY_LANE_W-1:0] tx_phy0;
  logic [PHY_LANE_W-1:0] tx_phy1;
  logic [PHY_LANE_W-1:0] tx_phy2;
  logic [PHY_LANE_W-1:0] rx_phy0;
  logic [PHY_LANE_W-1:0] rx_phy1;
  logic [PHY_LANE_W-1:0] rx_phy2;
  logic [3:0]            ustrm_state;
  logic [1:0]            ustrm_protid;
  logic [63:0]           ustrm_data;
  logic                  ustrm_dvalid;
  logic [15:0]           ustrm_crc;
  logic                  ustrm_crc_valid;
  logic                  ustrm_valid;

  word_fields_t sent_q[$];
  logic [31:0]  lfsr;
  int           errors;
  int           test_errors;
  int           tests_run;
  bit           abort;

  //////////////////////////////////////////////////
  // Clock, DUT and loopback
  //////////////////////////////////////////////////

  initial clk_wr = 1'b0;
  always #10 clk_wr = ~clk_wr;

  // External loopback, tx lanes straight into rx
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;

  lpif_link_top i_lpif_link_top (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  //////////////////////////////////////////////////
  // Random words and checks
  //////////////////////////////////////////////////

  // Galois step, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s >> 1;
    if (s[0]) begin
      lfsr_step = lfsr_step ^ LFSR_TAPS;
    end
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic make_word(output word_fields_t w);
    logic [63:0] r;
    draw_bits(64, r);
    w.data = r;
    draw_bits(16, r);
    w.crc = r[15:0];
    draw_bits(4, r);
    w.state = r[3:0];
    draw_bits(2, r);
    w.protid = r[1:0];
    draw_bits(2, r);
    w.dvalid = r[0];
    w.crc_valid = r[1];
    // Valid always set so gating shows up on it
    w.valid = 1'b1;
  endtask

  // Called right after a rising edge
  task automatic drive_word(input word_fields_t w);
    dstrm_state     <= w.state;
    dstrm_protid    <= w.protid;
    dstrm_data      <= w.data;
    dstrm_dvalid    <= w.dvalid;
    dstrm_crc       <= w.crc;
    dstrm_crc_valid <= w.crc_valid;
    dstrm_valid     <= w.valid;
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_word(input word_fields_t exp);
    check_value("ustrm_data", ustrm_data, exp.data);
    check_value("ustrm_crc", 64'(ustrm_crc), 64'(exp.crc));
    check_value("ustrm_state", 64'(ustrm_state), 64'(exp.state));
    check_value("ustrm_protid", 64'(ustrm_protid), 64'(exp.protid));
    check_value("ustrm_dvalid", 64'(ustrm_dvalid), 64'(exp.dvalid));
    check_value("ustrm_crc_valid", 64'(ustrm_crc_valid), 64'(exp.crc_valid));
    check_value("ustrm_valid", 64'(ustrm_valid), 64'(exp.valid));
  endtask

  // Idle lanes are all zero; live lanes carry the marker and a strobe every 8 cycles
  task automatic check_lanes(input bit online, input int idx);
    if (!online) begin
      check_value("tx_phy0", 64'(tx_phy0), 64'h0);
      check_value("tx_phy1", 64'(tx_phy1), 64'h0);
      check_value("tx_phy2", 64'(tx_phy2), 64'h0);
    end else begin
      check_value("tx_phy2 marker", 64'(tx_phy2[MRK_BIT - 2 * PHY_LANE_W]), 64'h1);
      check_value("tx_phy2 strobe", 64'(tx_phy2[STB_BIT - 2 * PHY_LANE_W]),
                  (idx % STROBE_INTERVAL == 0) ? 64'h1 : 64'h0);
    end
  endtask

  //////////////////////////////////////////////////
  // One phase of the stimulus file
  //////////////////////////////////////////////////

  task automatic run_phase(input logic [159:0] name, input int x, input int xz, input int yz,
                           input bit txo, input bit rxo, input int count, input bit expv);
    word_fields_t w;
    word_fields_t zero_w;
    int           cyc;
    int           idx;
    test_errors = 0;
    zero_w = '0;
    idx = 0;
    sent_q.delete();
    // Both sides offline so the link drains
    @(posedge clk_wr);
    tx_online      <= 1'b0;
    rx_online      <= 1'b0;
    delay_x_value  <= 8'(x);
    delay_xz_value <= 8'(xz);
    delay_yz_value <= 8'(yz);
    drive_word(zero_w);
    repeat (4) @(posedge clk_wr);
    tx_online <= txo;
    rx_online <= rxo;
    if (txo) begin
      // Lanes wake after the driven edge, xz counts and the lane register
      cyc = 0;
      @(negedge clk_wr);
      while ({tx_phy2, tx_phy1, tx_phy0} == '0 && cyc < TIMEOUT_CYCLES) begin
        cyc++;
        @(negedge clk_wr);
      end
      if (cyc >= TIMEOUT_CYCLES) begin
        $display("Timeout: tx lanes never came online in test %0s", name);
        errors++;
        test_errors++;
        abort = 1'b1;
        return;
      end
      check_value("tx lane latency", 64'(cyc), 64'(xz + 2));
      check_lanes(1'b1, idx);
    end
    // Words land on ustrm 3 cycles after they are driven
    for (int i = 0; i < count + 3; i++) begin
      @(posedge clk_wr);
      make_word(w);
      drive_word(w);
      sent_q.push_back(w);
      @(negedge clk_wr);
      idx++;
      check_lanes(txo, idx);
      if (sent_q.size() == 4) begin
        w = sent_q.pop_front();
        compare_word(expv ? w : zero_w);
      end
    end
    // Drop offline with words still flowing
    if (txo) begin
      for (int k = 0; k < 4; k++) begin
        @(posedge clk_wr);
        if (k == 0) begin
          tx_online <= 1'b0;
        end
        make_word(w);
        drive_word(w);
        @(negedge clk_wr);
        if (k >= 2) begin
          check_lanes(1'b0, 0);
        end
        if (k == 3) begin
          check_value("ustrm_valid after drop", 64'(ustrm_valid), 64'h0);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int           fd;
    int           n;
    string        line;
    logic [159:0] tname;
    int           x;
    int           xz;
    int           yz;
    int           txo;
    int           rxo;
    int           count;
    int           expv;
    rst_n          <= 1'b0;
    tx_online      <= 1'b0;
    rx_online      <= 1'b0;
    delay_x_value  <= 8'h0;
    delay_xz_value <= 8'h0;
    delay_yz_value <= 8'h0;
    drive_word('0);
    lfsr = LFSR_SEED;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    abort = 1'b0;
    repeat (5) @(posedge clk_wr);
    rst_n <= 1'b1;
    // Quiet out of reset
    @(negedge clk_wr);
    check_lanes(1'b0, 0);
    check_value("ustrm_valid after reset", 64'(ustrm_valid), 64'h0);
    fd = $fopen("bench/lpif_link_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/lpif_link_stimulus.txt for reading");
      errors++;
    end else begin
      while (!abort && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %d %d %d %d %d %d %d", tname, x, xz, yz, txo, rxo, count, expv);
        if (line.getc(0) != "#" && n == 8) begin
          tests_run++;
          run_phase(tname, x, xz, yz, txo[0], rxo[0], count, expv[0]);
          if (test_errors == 0) begin
            $display("test %0s: ok", tname);
          end else begin
            $display("test %0s: %0d errors", tname, test_errors);
          end
        end
      end
      $fclose(fd);
    end
    $display("Totals: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/lpif_link_stimulus.txt ====
# name delay_x delay_xz delay_yz tx_online rx_online words expect_valid
# expect_valid 1: ustrm carries each word 3 cycles later; 0: ustrm stays zero
loopback      2  3  2  1 1 24 1
zero_delay    0  0  0  1 1 16 1
long_xz       1 12  1  1 1 16 1
rx_offline    2  3  2  1 0 12 0
rx_slow_x    60  2  1  1 1 12 0
rx_slow_yz    1  2 50  1 1 12 0
tx_offline    1  1  1  0 1 10 0
strobe_run    0  5  0  1 1 40 1

// ==== sim.f ====
source/lpif_link_pkg.sv
source/link_auto_sync.sv
source/lpif_field_pack.sv
source/phy_lane_concat.sv
source/lpif_link_top.sv
bench/lpif_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the logic link testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module lpif_link_tb -f sim.f -o lpif_link_sim
./obj_dir/lpif_link_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished clean"
